// File: vlog.f
design/array_cfg_pkg.sv
design/drive_types_pkg.sv
design/pwm_timebase.sv
design/drive_cmd_dispatcher.sv
design/transducer_lane.sv
design/pin_mapper.sv
design/xdcr_array_top.sv
sim/xdcr_array_tb.sv

// File: Bender.yml
package:
  name: xdcr_array

sources:
  - target: any(simulation, synthesis)
    files:
      - design/array_cfg_pkg.sv
      - design/drive_types_pkg.sv
      - design/pwm_timebase.sv
      - design/drive_cmd_dispatcher.sv
      - design/transducer_lane.sv
      - design/pin_mapper.sv
      - design/xdcr_array_top.sv
  - target: simulation
    files:
      - sim/xdcr_array_tb.sv

// File: sim/xdcr_array_tb.sv
`timescale 1ns/1ps

module xdcr_array_tb
    import array_cfg_pkg::*;
    import drive_types_pkg::*;
();

    localparam int HAND_ROWS      = 6;
    localparam int RAND_ROWS      = 8;
    localparam int ROWS           = HAND_ROWS + RAND_ROWS;
    localparam int TIMEOUT_CYCLES = (ROWS + 2) * 20 * PWM_CYCLE;
    // 16 silencer steps plus up to one period before the first tick
    localparam int SETTLE_LIMIT   = 17 * PWM_CYCLE + 4;

    typedef struct packed {
        drive_cmd_t cmd;
        logic       expect_drop;
    } row_t;

    logic              clk_l = 1'b0;
    logic              rst;
    logic              cmd_valid;
    drive_cmd_t        cmd;
    logic              credit_ret;
    logic [NUM_CH-1:0] pins;
    logic [NUM_CH-1:0] settled;

    row_t              table_rows [ROWS];
    drive_set_t        model_target [NUM_CH];
    logic [CNT_W-1:0]  model_cnt;
    logic [CNT_W-1:0]  cnt_d1;
    logic [CNT_W-1:0]  cnt_d2;
    int                credits;
    int                pulses;
    int                cycles = 0;
    integer            seed = 29594;
    logic              win_open;
    logic              have_prev;
    int                win_high;
    int                prev_high;

    xdcr_array_top xdcr_array_top_i (
        .clk_l      (clk_l),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .credit_ret (credit_ret),
        .pins       (pins),
        .settled    (settled)
    );

    always #10 clk_l = ~clk_l;

    // Count model, plus the two cycle lag of the lane and pin registers
    always @(posedge clk_l) begin
        if (rst) begin
            model_cnt <= '0;
        end else if (model_cnt == CNT_W'(PWM_CYCLE - 1)) begin
            model_cnt <= '0;
        end else begin
            model_cnt <= model_cnt + CNT_W'(1);
        end
        cnt_d1 <= model_cnt;
        cnt_d2 <= cnt_d1;
    end

    always @(posedge clk_l) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the run did not finish within its cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_pins(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED pins got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_settled(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED settled got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_credits(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic drive_cmd_t make_cmd(input int ch, input int duty, input int phase);
        drive_cmd_t c;
        c.ch        = CH_IDX_W'(ch);
        c.set.duty  = CNT_W'(duty);
        c.set.phase = CNT_W'(phase);
        return c;
    endfunction

    // High when (count - phase) mod period is below duty, at the mapped pin
    function automatic logic [NUM_CH-1:0] expected_pins(input logic [CNT_W-1:0] c);
        logic [NUM_CH-1:0] v;
        int                rel;
        int                k;
        v = '0;
        for (k = 0; k < NUM_CH; k++) begin
            rel = (int'(c) - int'(model_target[k].phase) + PWM_CYCLE) % PWM_CYCLE;
            v[pin_of_lane(k)] = (rel < int'(model_target[k].duty));
        end
        return v;
    endfunction

    task automatic build_table();
        drive_set_t shadow [NUM_CH];
        integer     r;
        int         i;
        int         ch;
        int         duty;
        int         phase;
        table_rows[0].cmd = make_cmd(2, 511, 0);
        table_rows[1].cmd = make_cmd(2, 0, 0);
        table_rows[2].cmd = make_cmd(5, 256, 500);
        table_rows[3].cmd = make_cmd(5, 256, 20);
        table_rows[4].cmd = make_cmd(0, 0, 0);
        table_rows[5].cmd = make_cmd(7, 500, 256);
        for (i = HAND_ROWS; i < ROWS; i++) begin
            r     = $random(seed);
            ch    = r & (NUM_CH - 1);
            r     = $random(seed);
            duty  = r & (PWM_CYCLE - 1);
            r     = $random(seed);
            phase = r & (PWM_CYCLE - 1);
            table_rows[i].cmd = make_cmd(ch, duty, phase);
        end
        // A lane only leaves the settled state if its target really changes
        for (i = 0; i < NUM_CH; i++) begin
            shadow[i] = '0;
        end
        for (i = 0; i < ROWS; i++) begin
            ch = int'(table_rows[i].cmd.ch);
            table_rows[i].expect_drop = (shadow[ch] != table_rows[i].cmd.set);
            shadow[ch] = table_rows[i].cmd.set;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_l);
        if (credit_ret === 1'b1) begin
            credits++;
            pulses++;
        end
    endtask

    task automatic send_cmd(input drive_cmd_t c);
        if (credits <= 0) begin
            abort_run("Host tried to send a command without holding a credit");
        end
        cmd_valid = 1'b1;
        cmd       = c;
        credits--;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    // Windows run from count 1 to count 0, the span of one silencer setting
    task automatic track_slew(input logic pin);
        if (cnt_d2 == CNT_W'(1)) begin
            win_open = 1'b1;
            win_high = 0;
        end
        if (win_open) begin
            if (pin) begin
                win_high++;
            end
            if (cnt_d2 == '0) begin
                if (have_prev && (win_high - prev_high > int'(DUTY_STEP) ||
                                  prev_high - win_high > int'(DUTY_STEP))) begin
                    abort_run($sformatf("Pin high time jumped from %0d to %0d cycles in one period",
                                        prev_high, win_high));
                end
                prev_high = win_high;
                have_prev = 1'b1;
                win_open  = 1'b0;
            end
        end
    endtask

    task automatic apply_row(input row_t row);
        int                ch;
        int                wait_n;
        logic [NUM_CH-1:0] exp_settled;
        ch     = int'(row.cmd.ch);
        pulses = 0;
        send_cmd(row.cmd);
        wait_n = 0;
        while (pulses == 0) begin
            if (wait_n > CMD_CREDITS + 2) begin
                abort_run("No credit came back for a command");
            end
            next_cycle();
            wait_n++;
        end
        model_target[ch] = row.cmd.set;
        // Target loads one cycle after the pop, settled is registered one more
        next_cycle();
        next_cycle();
        exp_settled = '1;
        if (row.expect_drop) begin
            exp_settled[ch] = 1'b0;
        end
        check_settled(settled, exp_settled);
        win_open  = 1'b0;
        have_prev = 1'b0;
        wait_n    = 0;
        while (settled[ch] !== 1'b1) begin
            if (wait_n > SETTLE_LIMIT) begin
                abort_run($sformatf("Lane %0d did not settle within 16 silencer steps", ch));
            end
            next_cycle();
            wait_n++;
            check_settled(settled | (NUM_CH'(1) << ch), '1);
            track_slew(pins[pin_of_lane(ch)]);
        end
        next_cycle();
        repeat (PWM_CYCLE) begin
            next_cycle();
            check_pins(pins, expected_pins(cnt_d2));
            check_settled(settled, '1);
        end
        check_credits("credits", credits, CMD_CREDITS);
    endtask

    initial begin
        int i;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        credits   = CMD_CREDITS;
        pulses    = 0;
        win_open  = 1'b0;
        have_prev = 1'b0;
        win_high  = 0;
        prev_high = 0;
        for (i = 0; i < NUM_CH; i++) begin
            model_target[i] = '0;
        end
        build_table();
        repeat (3) @(negedge clk_l);
        rst = 1'b0;

        // Idle array after reset
        next_cycle();
        next_cycle();
        repeat (8) begin
            check_pins(pins, '0);
            check_settled(settled, '1);
            check_credits("credit_ret pulses", pulses, 0);
            next_cycle();
        end

        // Burst that spends every credit, targets stay at their reset value
        pulses = 0;
        for (i = 0; i < CMD_CREDITS; i++) begin
            send_cmd(make_cmd(i, 0, 0));
        end
        repeat (4 * CMD_CREDITS) begin
            next_cycle();
            check_settled(settled, '1);
        end
        check_credits("credit_ret pulses", pulses, CMD_CREDITS);
        check_credits("credits", credits, CMD_CREDITS);

        for (i = 0; i < ROWS; i++) begin
            apply_row(table_rows[i]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: design/xdcr_array_top.sv
`timescale 1ns/1ps

module xdcr_array_top
    import array_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  logic              clk_l,
    input  logic              rst,
    input  logic              cmd_valid,
    input  drive_cmd_t        cmd,
    output logic              credit_ret,
    output logic [NUM_CH-1:0] pins,
    output logic [NUM_CH-1:0] settled
);

    logic [CNT_W-1:0]  cnt;
    logic              period_start;
    logic [NUM_CH-1:0] lane_wr;
    drive_set_t        lane_set;
    logic [NUM_CH-1:0] lane_pwm;
    logic [NUM_CH-1:0] lane_settled;

    pwm_timebase pwm_timebase_i (
        .clk_l        (clk_l),
        .rst          (rst),
        .cnt          (cnt),
        .period_start (period_start)
    );

    drive_cmd_dispatcher drive_cmd_dispatcher_i (
        .clk_l      (clk_l),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .credit_ret (credit_ret),
        .lane_wr    (lane_wr),
        .lane_set   (lane_set)
    );

    // One lane per transducer channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_lane
        transducer_lane transducer_lane_i (
            .clk_l        (clk_l),
            .rst          (rst),
            .cnt          (cnt),
            .period_start (period_start),
            .wr           (lane_wr[i]),
            .set          (lane_set),
            .pwm          (lane_pwm[i]),
            .settled      (lane_settled[i])
        );
    end

    pin_mapper pin_mapper_i (
        .clk_l        (clk_l),
        .rst          (rst),
        .lane_pwm     (lane_pwm),
        .lane_settled (lane_settled),
        .pins         (pins),
        .settled      (settled)
    );

endmodule

// File: design/pin_mapper.sv
`timescale 1ns/1ps

module pin_mapper
    import array_cfg_pkg::*;
(
    input  logic              clk_l,
    input  logic              rst,
    input  logic [NUM_CH-1:0] lane_pwm,
    input  logic [NUM_CH-1:0] lane_settled,
    output logic [NUM_CH-1:0] pins,
    output logic [NUM_CH-1:0] settled
);

    logic [NUM_CH-1:0] mapped;

    // Lane order to physical wiring order
    for (genvar k = 0; k < NUM_CH; k++) begin : g_map
        assign mapped[pin_of_lane(k)] = lane_pwm[k];
    end

    // Output stage, settled stays in lane order
    always_ff @(posedge clk_l) begin
        if (rst) begin
            pins    <= '0;
            settled <= '0;
        end else begin
            pins    <= mapped;
            settled <= lane_settled;
        end
    end

endmodule

// File: design/transducer_lane.sv
`timescale 1ns/1ps

module transducer_lane
    import array_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  logic             clk_l,
    input  logic             rst,
    input  logic [CNT_W-1:0] cnt,
    input  logic             period_start,
    input  logic             wr,
    input  drive_set_t       set,
    output logic             pwm,
    output logic             settled
);

    drive_set_t       target;
    drive_set_t       cur;
    drive_set_t       cur_next;
    logic [CNT_W-1:0] duty_up;
    logic [CNT_W-1:0] duty_dn;
    logic [CNT_W-1:0] phase_up;
    logic [CNT_W-1:0] phase_dn;
    logic [CNT_W-1:0] rel_cnt;

    always_ff @(posedge clk_l) begin
        if (rst) begin
            target <= '0;
        end else if (wr) begin
            target <= set;
        end
    end

    // Distances toward the target, phase ones wrap around the period
    always_comb begin
        duty_up  = target.duty - cur.duty;
        duty_dn  = cur.duty - target.duty;
        phase_up = target.phase - cur.phase;
        phase_dn = cur.phase - target.phase;
        cur_next = cur;

        if (target.duty > cur.duty) begin
            cur_next.duty = cur.duty + ((duty_up > DUTY_STEP) ? DUTY_STEP : duty_up);
        end else if (target.duty < cur.duty) begin
            cur_next.duty = cur.duty - ((duty_dn > DUTY_STEP) ? DUTY_STEP : duty_dn);
        end

        // Shorter way round, exactly half a period goes up
        if (phase_up != '0) begin
            if (phase_up <= PHASE_HALF) begin
                cur_next.phase = cur.phase + ((phase_up > PHASE_STEP) ? PHASE_STEP : phase_up);
            end else begin
                cur_next.phase = cur.phase - ((phase_dn > PHASE_STEP) ? PHASE_STEP : phase_dn);
            end
        end
    end

    // Silencer steps once per period
    always_ff @(posedge clk_l) begin
        if (rst) begin
            cur <= '0;
        end else if (period_start) begin
            cur <= cur_next;
        end
    end

    assign rel_cnt = cnt - cur.phase;

    always_ff @(posedge clk_l) begin
        if (rst) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (rel_cnt < cur.duty);
        end
    end

    assign settled = (cur == target);

    // Slew bound on the acoustic output, checked across the period update
    a_duty_slew: assert property (
        @(posedge clk_l) disable iff (rst)
        period_start |=> ((cur.duty >= $past(cur.duty)) ?
            ((cur.duty - $past(cur.duty)) <= DUTY_STEP) :
            (($past(cur.duty) - cur.duty) <= DUTY_STEP))
    ) else $error("duty step exceeds limit");

endmodule

// File: design/drive_cmd_dispatcher.sv
`timescale 1ns/1ps

module drive_cmd_dispatcher
    import array_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  logic              clk_l,
    input  logic              rst,
    input  logic              cmd_valid,
    input  drive_cmd_t        cmd,
    output logic              credit_ret,
    output logic [NUM_CH-1:0] lane_wr,
    output drive_set_t        lane_set
);

    drive_cmd_t       fifo_mem [CMD_CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occ;
    logic             push;
    logic             pop;
    logic             full;
    drive_cmd_t       head;

    // No ready signal, the host only sends while it holds a credit
    assign push = cmd_valid;
    assign pop  = (occ != '0);
    assign full = (occ == OCC_W'(CMD_CREDITS));
    assign head = fifo_mem[rd_ptr];

    always_ff @(posedge clk_l) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk_l) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   occ <= occ + OCC_W'(1);
                2'b01:   occ <= occ - OCC_W'(1);
                default: occ <= occ;
            endcase
        end
    end

    // Head entry goes out in its pop cycle, one credit back per pop
    always_comb begin
        lane_wr = '0;
        if (pop) begin
            lane_wr = NUM_CH'(1) << head.ch;
        end
    end

    assign lane_set   = head.set;
    assign credit_ret = pop;

    // Host pushing into a full FIFO has spent a credit it did not hold
    a_no_push_when_full: assert property (
        @(posedge clk_l) disable iff (rst)
        !(push && full)
    ) else $error("command accepted while FIFO full");

endmodule

// File: design/pwm_timebase.sv
`timescale 1ns/1ps

module pwm_timebase
    import array_cfg_pkg::*;
(
    input  logic             clk_l,
    input  logic             rst,
    output logic [CNT_W-1:0] cnt,
    output logic             period_start
);

    // Shared period counter, every lane takes its phase reference from it
    always_ff @(posedge clk_l) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(PWM_CYCLE - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    // Tick that paces the silencers
    assign period_start = (cnt == '0);

endmodule

// File: design/drive_types_pkg.sv
package drive_types_pkg;

    import array_cfg_pkg::*;

    // Drive setting of one channel
    typedef struct packed {
        logic [CNT_W-1:0] duty;
        logic [CNT_W-1:0] phase;
    } drive_set_t;

    // Host command, addressed to one channel
    typedef struct packed {
        logic [CH_IDX_W-1:0] ch;
        drive_set_t          set;
    } drive_cmd_t;

endpackage

// File: design/array_cfg_pkg.sv
package array_cfg_pkg;

    // Array geometry
    localparam int NUM_CH   = 8;
    localparam int CH_IDX_W = $clog2(NUM_CH);

    // PWM period is a power of two so duty, phase and count all wrap together
    localparam int CNT_W     = 9;
    localparam int PWM_CYCLE = 1 << CNT_W;

    // Half a period, the tie point for the shortest phase path
    localparam logic [CNT_W-1:0] PHASE_HALF = CNT_W'(PWM_CYCLE / 2);

    // Largest change the silencer applies per period
    localparam logic [CNT_W-1:0] DUTY_STEP  = CNT_W'(32);
    localparam logic [CNT_W-1:0] PHASE_STEP = CNT_W'(32);

    // Command FIFO depth, equal to the host's credit count after reset
    localparam int CMD_CREDITS = 4;
    localparam int PTR_W       = $clog2(CMD_CREDITS);
    localparam int OCC_W       = $clog2(CMD_CREDITS + 1);

    // Physical pin index of a lane, a fixed permutation of the array wiring
    function automatic int pin_of_lane(input int lane);
        return (lane * 3 + 1) % NUM_CH;
    endfunction

endpackage
